// ==== sources.f ====
logic/c1Pkg.sv
logic/c1Decode.sv
logic/c1Wait.sv
logic/c1Regs.sv
logic/neoC1.sv
testbench/neoC1_chk.sv
testbench/neoC1Tb.sv

// ==== run.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module neoC1Tb -f sources.f -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

simOut=$(./obj_dir/VneoC1Tb)
simStatus=$?
printf '%s\n' "$simOut"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with an error status"
	exit 1
fi

if printf '%s\n' "$simOut" | grep -qx 'STATUS: PASS'; then
	exit 0
fi
echo "Simulation output has no pass line"
exit 1

// ==== testbench/neoC1Tb.sv ====
`timescale 1ns/100ps

module neoC1Tb;
	import c1Pkg::*;

	localparam logic boardMode = 1'b0;	// Console build
	localparam logic [1:0] cardWaitSet = 2'd3;
	localparam int cycleCount = 500;
	localparam int dtackTimeout = 32;
	localparam cpuBus_t idleBus = '{addr: 7'h00, rw: 1'b1, nAs: 1'b1, nLds: 1'b1, nUds: 1'b1};
	localparam memStrobes_t noStrobes = '1;

	logic clk68k;
	logic rst;
	cpuBus_t cpuBus;
	logic [7:0] cpuData;
	logic nRomWait;
	logic nPWait0;
	logic nPWait1;
	logic pDtack;
	logic nCd1;
	logic nCd2;
	logic nWp;
	logic [7:0] p1In;
	logic [7:0] p2In;
	logic [7:0] sdd;
	memStrobes_t strobes;
	logic [7:0] dataOut;
	logic dataOe;
	logic [7:0] soundCode;
	logic nSdw;
	logic nDtack;

	logic [31:0] lfsr;
	logic [7:0] expSound;	// Sound latch as the model tracks it

	neoC1 #(.consoleMode(boardMode), .cardWait(cardWaitSet)) uut (.*);

	initial begin
		clk68k = 1'b0;
		forever #5 clk68k = ~clk68k;
	end

	// Taps 32, 22, 2, 1
	function logic [31:0] nextBits(input int count);
		logic [31:0] result;
		logic fb;
		int i;
		result = '0;
		for (i = 0; i < count; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			result = {result[30:0], fb};
		end
		return result;
	endfunction

	task failRun(input string why);
		$display("%s", why);
		$display("STATUS: FAIL");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task checkStrobes(input string name, input memStrobes_t exp, input memStrobes_t act);
		if (exp !== act)
			failRun($sformatf("ERROR: %s expected 0x%h got 0x%h", name, exp, act));
	endtask

	task checkByte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (exp !== act)
			failRun($sformatf("ERROR: %s expected 0x%h got 0x%h", name, exp, act));
	endtask

	task checkBit(input string name, input logic exp, input logic act);
		if (exp !== act)
			failRun($sformatf("ERROR: %s expected 0x%h got 0x%h", name, exp, act));
	endtask

	// Address map of the glue chip in 1 MB regions and IO sub-zones
	function memStrobes_t modelStrobes(input cpuBus_t b);
		memStrobes_t s;
		logic [2:0] sub;
		logic [1:0] lanes;
		s = '1;
		sub = b.addr[2:0];
		lanes = {~b.nUds, ~b.nLds};
		if (!b.nAs) begin
			case (b.addr[6:3])
				4'h0: begin
					if (b.rw) s.nRomOe = ~lanes;
				end
				4'h1: begin
					if (b.rw) s.nWr = ~lanes;
					else s.nWw = ~lanes;
				end
				4'h2: begin
					if (b.rw) s.nPortOe = ~lanes;
					else s.nPortWe = ~lanes;
					s.nPortAdrs = (lanes == 2'b00);
				end
				4'h3: begin
					if (lanes == 2'b11 && sub == 3'd6) begin	// Video controller takes words only
						if (b.rw) s.nLspOe = 1'b0;
						else s.nLspWe = 1'b0;
					end
					if (lanes[1] && b.rw) begin
						s.nCtrl1Zone = (sub != 3'd0);
						s.nCtrl2Zone = !(sub == 3'd2 || sub == 3'd3);
						s.nStatusBZone = (sub != 3'd4);
					end
					if (lanes[0] && b.rw) begin
						s.nDipRd[0] = (sub != 3'd0);
						s.nDipRd[1] = (sub != 3'd1);
					end
					if (lanes[0] && !b.rw) begin
						s.nBitW[0] = (sub != 3'd4);
						s.nBitW[1] = (sub != 3'd5);
					end
				end
				4'h4, 4'h5, 4'h6, 4'h7: s.nPal = 1'b0;
				4'h8, 4'h9, 4'hA, 4'hB: begin
					if (lanes == 2'b11) begin
						if (b.rw) s.nCrdo = 1'b0;
						else s.nCrdw = 1'b0;
						s.nCrdc = 1'b0;
					end
				end
				4'hC: begin
					if (b.rw) s.nSromOe = ~lanes;
				end
				4'hD: begin
					if (b.rw) s.nSramOe = ~lanes;
					else s.nSramWe = ~lanes;
				end
				default: s = '1;
			endcase
		end
		return s;
	endfunction

	task runBusCycle;
		cpuBus_t b;
		memStrobes_t expStrobes;
		logic [31:0] rnd;
		logic [7:0] data;
		logic [7:0] pad1;
		logic [7:0] pad2;
		logic [7:0] reply;
		logic cd1;
		logic cd2;
		logic wp;
		logic romW;
		logic pw0;
		logic pw1;
		logic pdStart;
		logic [1:0] extra;
		logic isPort;
		logic icomWrite;
		logic expOe;
		logic [7:0] expData;
		int portHold;
		int dropEdge;
		int e;

		rnd = nextBits(7);
		b.addr = rnd[6:0];
		if (nextBits(2) == 32'd0) b.addr[6:3] = 4'h3;	// Favor the IO zone
		rnd = nextBits(3);
		b.rw = rnd[2];
		b.nUds = rnd[1];
		b.nLds = rnd[0];
		b.nAs = 1'b0;
		rnd = nextBits(8);
		data = rnd[7:0];
		rnd = nextBits(8);
		pad1 = rnd[7:0];
		rnd = nextBits(8);
		pad2 = rnd[7:0];
		rnd = nextBits(8);
		reply = rnd[7:0];
		rnd = nextBits(10);
		{cd1, cd2, wp, romW, pw0, pw1, pdStart} = rnd[6:0];
		portHold = int'(rnd[9:7]);

		isPort = (b.addr[6:3] == 4'h2);
		if (isPort) pdStart = (portHold == 0);
		case (b.addr[6:3])
			4'h0: extra = {1'b0, ~romW};
			4'h2: extra = {~pw1, ~pw0};
			4'h8, 4'h9, 4'hA, 4'hB: extra = cardWaitSet;
			default: extra = 2'd0;
		endcase
		dropEdge = 1 + int'(extra);
		if (isPort && portHold > dropEdge) dropEdge = portHold;

		expStrobes = modelStrobes(b);
		icomWrite = (b.addr[6:3] == 4'h3) && !b.nUds && !b.rw && (b.addr[2:0] == 3'd1);
		expOe = 1'b0;
		expData = 8'h00;
		if (b.addr[6:3] == 4'h3 && !b.nUds && b.rw) begin
			expOe = (b.addr[2:0] <= 3'd4);
			case (b.addr[2:0])
				3'd0: expData = pad1;
				3'd1: expData = reply;
				3'd2, 3'd3: expData = pad2;
				default: expData = {boardMode, wp, cd2, cd1, 4'hF};
			endcase
		end

		@(posedge clk68k);
		cpuBus <= b;
		cpuData <= data;
		p1In <= pad1;
		p2In <= pad2;
		sdd <= reply;
		{nCd1, nCd2, nWp, nRomWait, nPWait0, nPWait1, pDtack} <=
			{cd1, cd2, wp, romW, pw0, pw1, pdStart};
		@(negedge clk68k);
		checkStrobes("strobes", expStrobes, strobes);
		checkBit("dataOe", expOe, dataOe);
		if (expOe) checkByte("dataOut", expData, dataOut);

		// Edge 0 is the first one that samples nAs low
		e = -1;
		do begin
			if (e >= dtackTimeout)
				failRun($sformatf("No nDtack for the bus cycle at address 0x%h", b.addr));
			@(posedge clk68k);
			e = e + 1;
			if (isPort && portHold > 0 && e == portHold - 1) pDtack <= 1'b1;
			if (e == 0 && icomWrite) expSound = data;
			@(negedge clk68k);
			checkStrobes("strobes", expStrobes, strobes);
			checkBit("nDtack", e < dropEdge, nDtack);
			checkBit("nSdw", !(e == 0 && icomWrite), nSdw);
			checkByte("soundCode", expSound, soundCode);
		end while (nDtack);

		@(posedge clk68k);
		b.nAs = 1'b1;	// Address and lanes still driven as nAs rises
		cpuBus <= b;
		@(negedge clk68k);
		checkBit("nDtack", 1'b0, nDtack);	// Held until nAs is sampled high
		checkStrobes("strobes", noStrobes, strobes);
		checkBit("dataOe", 1'b0, dataOe);
		@(posedge clk68k);
		@(negedge clk68k);
		checkBit("nDtack", 1'b1, nDtack);
		checkBit("nSdw", 1'b1, nSdw);
	endtask

	initial begin
		int n;
		lfsr = 32'h4804b95f;
		expSound = 8'h00;
		rst <= 1'b1;
		cpuBus <= idleBus;
		cpuData <= 8'h00;
		{nRomWait, nPWait0, nPWait1, pDtack} <= 4'hF;
		{nCd1, nCd2, nWp} <= 3'b111;
		p1In <= 8'h00;
		p2In <= 8'h00;
		sdd <= 8'h00;
		repeat (2) @(posedge clk68k);
		rst <= 1'b0;

		@(negedge clk68k);
		checkBit("nDtack", 1'b1, nDtack);
		checkBit("nSdw", 1'b1, nSdw);
		checkBit("dataOe", 1'b0, dataOe);
		checkByte("soundCode", 8'h00, soundCode);
		checkStrobes("strobes", noStrobes, strobes);

		for (n = 0; n < cycleCount; n++)
			runBusCycle();

		$display("STATUS: PASS");
		$finish;
	end

endmodule

// ==== testbench/neoC1_chk.sv ====
`timescale 1ns/100ps

module neoC1_chk (
	input logic clk68k,
	input logic rst,
	input logic nAs,
	input logic nDtack,
	input logic nSdw
);

	// DTACK releases on the edge after the strobe goes away
	dtackRelease: assert property (@(posedge clk68k) disable iff (rst)
		$rose(nAs) |=> nDtack)
		else $error("nDtack still low one cycle after nAs rose");

	dtackInCycle: assert property (@(posedge clk68k) disable iff (rst)
		$fell(nDtack) |-> !nAs)
		else $error("nDtack asserted outside a bus cycle");

	// Command strobe is a single cycle pulse
	sdwSingle: assert property (@(posedge clk68k) disable iff (rst)
		!nSdw |=> nSdw)
		else $error("nSdw low for two cycles in a row");

	sdwInCycle: assert property (@(posedge clk68k) disable iff (rst)
		!nSdw |-> !nAs)
		else $error("nSdw low while no bus cycle runs");

endmodule

bind c1Wait neoC1_chk waitChk (.clk68k(clk68k), .rst(rst), .nAs(nAs),
	.nDtack(nDtack), .nSdw(1'b1));
bind c1Regs neoC1_chk regsChk (.clk68k(clk68k), .rst(rst), .nAs(nAs),
	.nDtack(1'b1), .nSdw(nSdw));

// ==== logic/neoC1.sv ====
`timescale 1ns/100ps

module neoC1 #(
	parameter logic consoleMode = 1'b1,	// 1 = arcade board
	parameter logic [1:0] cardWait = 2'd2
) (
	input logic clk68k,
	input logic rst,
	input c1Pkg::cpuBus_t cpuBus,
	input logic [7:0] cpuData,
	input logic nRomWait,
	input logic nPWait0,
	input logic nPWait1,
	input logic pDtack,
	input logic nCd1,
	input logic nCd2,
	input logic nWp,
	input logic [7:0] p1In,
	input logic [7:0] p2In,
	input logic [7:0] sdd,
	output c1Pkg::memStrobes_t strobes,
	output logic [7:0] dataOut,
	output logic dataOe,
	output logic [7:0] soundCode,
	output logic nSdw,
	output logic nDtack
);
	import c1Pkg::*;

	zone_t zone;
	regSel_t regSel;

	c1Decode decode (
		.bus(cpuBus),
		.strobes(strobes),
		.zone(zone),
		.regSel(regSel)
	);

	c1Regs #(
		.consoleMode(consoleMode)
	) regs (
		.clk68k(clk68k),
		.rst(rst),
		.rw(cpuBus.rw),
		.nAs(cpuBus.nAs),
		.regSel(regSel),
		.cpuData(cpuData),
		.p1In(p1In),
		.p2In(p2In),
		.sdd(sdd),
		.nCd1(nCd1),
		.nCd2(nCd2),
		.nWp(nWp),
		.dataOut(dataOut),
		.dataOe(dataOe),
		.soundCode(soundCode),
		.nSdw(nSdw)
	);

	c1Wait #(
		.cardWait(cardWait)
	) waitGen (
		.clk68k(clk68k),
		.rst(rst),
		.nAs(cpuBus.nAs),
		.zone(zone),
		.nRomWait(nRomWait),
		.nPWait0(nPWait0),
		.nPWait1(nPWait1),
		.pDtack(pDtack),
		.nDtack(nDtack)
	);

endmodule

// ==== logic/c1Regs.sv ====
`timescale 1ns/100ps

module c1Regs #(
	parameter logic consoleMode = 1'b1
) (
	input logic clk68k,
	input logic rst,
	input logic rw,
	input logic nAs,
	input c1Pkg::regSel_t regSel,
	input logic [7:0] cpuData,
	input logic [7:0] p1In,
	input logic [7:0] p2In,
	input logic [7:0] sdd,
	input logic nCd1,
	input logic nCd2,
	input logic nWp,
	output logic [7:0] dataOut,
	output logic dataOe,
	output logic [7:0] soundCode,
	output logic nSdw
);
	import c1Pkg::*;

	logic nAsPrev;
	logic cycStart;

	// Read mux for the even-byte registers
	always_comb begin
		case (regSel)
			REG_CTRL1: dataOut = p1In;
			REG_CTRL2: dataOut = p2In;
			REG_ICOM: dataOut = sdd;	// Sound CPU reply
			REG_STATUSB: dataOut = {consoleMode, nWp, nCd2, nCd1, 4'hF};
			default: dataOut = 8'h00;
		endcase
	end

	assign dataOe = rw & (regSel != REG_NONE);

	// Only the first low sample of nAs starts a command write
	assign cycStart = nAsPrev & ~nAs;

	always_ff @(posedge clk68k) begin
		if (rst) begin
			nAsPrev <= 1'b1;
			soundCode <= 8'h00;
			nSdw <= 1'b1;
		end else begin
			nAsPrev <= nAs;
			nSdw <= 1'b1;
			if (cycStart && !rw && regSel == REG_ICOM) begin
				soundCode <= cpuData;
				nSdw <= 1'b0;	// One-cycle pulse to the sound side
			end
		end
	end

endmodule

// ==== logic/c1Wait.sv ====
`timescale 1ns/100ps

module c1Wait #(
	parameter logic [1:0] cardWait = 2'd2
) (
	input logic clk68k,
	input logic rst,
	input logic nAs,
	input c1Pkg::zone_t zone,
	input logic nRomWait,
	input logic nPWait0,
	input logic nPWait1,
	input logic pDtack,
	output logic nDtack
);
	import c1Pkg::*;

	waitState_t state;
	logic [1:0] waitCnt;
	logic [1:0] zoneWait;

	// Extra wait states per zone
	always_comb begin
		case (zone)
			ZONE_ROM: zoneWait = {1'b0, ~nRomWait};
			ZONE_PORT: zoneWait = {~nPWait1, ~nPWait0};
			ZONE_CARD: zoneWait = cardWait;
			default: zoneWait = 2'd0;
		endcase
	end

	always_ff @(posedge clk68k) begin
		if (rst) begin
			state <= WAIT_IDLE;
			waitCnt <= 2'd0;
		end else if (nAs) begin
			state <= WAIT_IDLE;	// Cycle over, release DTACK
		end else begin
			case (state)
				WAIT_IDLE: begin
					waitCnt <= zoneWait;	// First edge with nAs low
					state <= WAIT_COUNT;
				end
				WAIT_COUNT: begin
					if (waitCnt != 2'd0) begin
						waitCnt <= waitCnt - 2'd1;
					end else if (zone == ZONE_PORT && !pDtack) begin
						state <= WAIT_PORT;	// Slot still busy
					end else begin
						state <= WAIT_ACK;
					end
				end
				WAIT_PORT: begin
					if (pDtack)
						state <= WAIT_ACK;
				end
				default: state <= WAIT_ACK;	// Hold until nAs rises
			endcase
		end
	end

	assign nDtack = (state != WAIT_ACK);

endmodule

// ==== logic/c1Decode.sv ====
`timescale 1ns/100ps

module c1Decode (
	input c1Pkg::cpuBus_t bus,
	output c1Pkg::memStrobes_t strobes,
	output c1Pkg::zone_t zone,
	output c1Pkg::regSel_t regSel
);
	import c1Pkg::*;

	logic [1:0] bSel;	// {upper, lower} byte lanes
	logic [2:0] sub;	// A19..A17 inside the IO zone
	logic rd;
	logic wr;
	logic word;
	logic ioHit;
	logic evenIo;
	logic oddIo;

	// Active-low pair from a zone hit and the byte lanes
	function automatic logic [1:0] pairStrobe(input logic hit, input logic [1:0] sel);
		return ~({2{hit}} & sel);
	endfunction

	assign bSel = {~bus.nUds, ~bus.nLds};
	assign sub = bus.addr[2:0];
	assign rd = bus.rw;
	assign wr = ~bus.rw;
	assign word = &bSel;

	// Megabyte regions from A23..A20
	always_comb begin
		zone = ZONE_NONE;
		if (!bus.nAs) begin
			case (bus.addr[6:3])
				4'h0: zone = ZONE_ROM;
				4'h1: zone = ZONE_WRAM;
				4'h2: zone = ZONE_PORT;
				4'h3: zone = ZONE_IO;
				4'h4, 4'h5, 4'h6, 4'h7: zone = ZONE_PAL;
				4'h8, 4'h9, 4'hA, 4'hB: zone = ZONE_CARD;
				4'hC: zone = ZONE_SROM;
				4'hD: zone = ZONE_SRAM;
				default: zone = ZONE_NONE;	// E and F are open bus
			endcase
		end
	end

	assign ioHit = (zone == ZONE_IO);
	assign evenIo = ioHit & bSel[1];
	assign oddIo = ioHit & bSel[0];

	// Even-byte I/O registers
	always_comb begin
		regSel = REG_NONE;
		if (evenIo) begin
			case (sub)
				3'd0: regSel = rd ? REG_CTRL1 : REG_NONE;
				3'd1: regSel = REG_ICOM;	// Read reply or write command
				3'd2, 3'd3: regSel = rd ? REG_CTRL2 : REG_NONE;
				3'd4: regSel = rd ? REG_STATUSB : REG_NONE;
				default: regSel = REG_NONE;
			endcase
		end
	end

	always_comb begin
		strobes = '1;

		strobes.nRomOe = pairStrobe(rd && zone == ZONE_ROM, bSel);
		strobes.nWr = pairStrobe(rd && zone == ZONE_WRAM, bSel);
		strobes.nWw = pairStrobe(wr && zone == ZONE_WRAM, bSel);
		strobes.nPortOe = pairStrobe(rd && zone == ZONE_PORT, bSel);
		strobes.nPortWe = pairStrobe(wr && zone == ZONE_PORT, bSel);
		strobes.nPortAdrs = ~((zone == ZONE_PORT) & |bSel);
		strobes.nSromOe = pairStrobe(rd && zone == ZONE_SROM, bSel);
		strobes.nSramOe = pairStrobe(rd && zone == ZONE_SRAM, bSel);
		strobes.nSramWe = pairStrobe(wr && zone == ZONE_SRAM, bSel);

		strobes.nPal = ~(zone == ZONE_PAL);

		// Card and video controller only take word accesses
		strobes.nCrdo = ~(rd & word & (zone == ZONE_CARD));
		strobes.nCrdw = ~(wr & word & (zone == ZONE_CARD));
		strobes.nCrdc = strobes.nCrdo & strobes.nCrdw;
		strobes.nLspOe = ~(rd & word & ioHit & (sub == 3'd6));
		strobes.nLspWe = ~(wr & word & ioHit & (sub == 3'd6));

		strobes.nCtrl1Zone = ~(regSel == REG_CTRL1);
		strobes.nCtrl2Zone = ~(regSel == REG_CTRL2);
		strobes.nStatusBZone = ~(regSel == REG_STATUSB);

		strobes.nDipRd[0] = ~(oddIo & rd & (sub == 3'd0));
		strobes.nDipRd[1] = ~(oddIo & rd & (sub == 3'd1));
		strobes.nBitW[0] = ~(oddIo & wr & (sub == 3'd4));
		strobes.nBitW[1] = ~(oddIo & wr & (sub == 3'd5));
	end

endmodule

// ==== logic/c1Pkg.sv ====
package c1Pkg;

	// One sampled 68000 bus state, upper address lines only
	typedef struct packed {
		logic [6:0] addr;	// A23..A17
		logic rw;	// 1 = read
		logic nAs;
		logic nLds;
		logic nUds;
	} cpuBus_t;

	// Active-low chip outputs, pairs are {upper, lower}
	typedef struct packed {
		logic [1:0] nRomOe;
		logic [1:0] nPortOe;
		logic [1:0] nPortWe;
		logic nPortAdrs;
		logic [1:0] nWr;	// Work RAM read
		logic [1:0] nWw;	// Work RAM write
		logic [1:0] nSromOe;
		logic [1:0] nSramOe;
		logic [1:0] nSramWe;
		logic nLspOe;	// Video controller
		logic nLspWe;
		logic nCrdo;
		logic nCrdw;
		logic nCrdc;
		logic nPal;
		logic [1:0] nDipRd;	// Index is the DIP bank number
		logic [1:0] nBitW;	// Index is the latch number
		logic nCtrl1Zone;
		logic nCtrl2Zone;
		logic nStatusBZone;
	} memStrobes_t;

	typedef enum logic [3:0] {
		ZONE_NONE = 4'd0,
		ZONE_ROM = 4'd1,
		ZONE_WRAM = 4'd2,
		ZONE_PORT = 4'd3,
		ZONE_IO = 4'd4,
		ZONE_PAL = 4'd5,
		ZONE_CARD = 4'd6,
		ZONE_SROM = 4'd7,
		ZONE_SRAM = 4'd8
	} zone_t;

	typedef enum logic [2:0] {
		REG_NONE = 3'd0,
		REG_CTRL1 = 3'd1,
		REG_ICOM = 3'd2,
		REG_CTRL2 = 3'd3,
		REG_STATUSB = 3'd4
	} regSel_t;

	typedef enum logic [1:0] {
		WAIT_IDLE = 2'd0,
		WAIT_COUNT = 2'd1,
		WAIT_PORT = 2'd2,
		WAIT_ACK = 2'd3
	} waitState_t;

endpackage
